// File: hw/glue_defines.svh
/*
 * sizing macros for the system glue logic
 * included by the packages, the RTL and the testbench
 */
`ifndef GLUE_DEFINES_SVH
`define GLUE_DEFINES_SVH

// ------------------------------
// reset sequencing
// ------------------------------

// sof pulses that reset is held after the request ends
`define GLUE_RESET_FRAMES 2

// depth of the cpu reset synchronizer
`define GLUE_SYNC_STAGES 2

// ------------------------------
// real time clock
// ------------------------------

`define GLUE_RTC_NIBBLES 16 // 4-bit fields in the rtc word

`endif

// File: hw/bus_pkg.sv
/*
 * m68k side bus types: address, data word and interrupt level
 * referenced by scoped name from the glue modules
 */
`include "glue_defines.svh"

package bus_pkg;

	// word address, a0 is implied by the byte strobes
	typedef logic [23:1] cpu_addr_t;

	// cia a drives d7..d0, cia b drives d15..d8
	typedef struct packed {
		logic [7:0] cia_b; // high lane
		logic [7:0] cia_a; // low lane
	} cia_lanes_t;

	// one cpu data word, seen raw or as the two cia byte lanes
	typedef union packed {
		logic [15:0] raw;
		cia_lanes_t  lane;
	} cpu_word_u;

	typedef logic [2:0] ipl_t; // active low, 3'b111 = no request

	// cpu reset synchronizer chain, one bit per stage
	typedef logic [`GLUE_SYNC_STAGES-1:0] cpu_rst_sync_t;

endpackage

// File: hw/config_pkg.sv
/*
 * configuration word layouts as delivered by the user io block
 * boot_config decodes these into the outputs of the core
 */
package config_pkg;

	// ------------------------------
	// chipset features
	// ------------------------------
	typedef struct packed {
		logic aga;   // aga chipset
		logic ecs;   // ecs chipset
		logic a1k;   // a1000 mode
		logic ntsc;  // video standard request, applied at reset
		logic turbo; // turbo mode
	} chipset_cfg_t;

	// memory layout, hrtmon_en stays with cia a
	typedef struct packed {
		logic       hrtmon_ext; // bit 7
		logic       hrtmon_en;  // bit 6
		logic [1:0] slow;       // slow ram size
		logic [1:0] chip;       // chip ram size
		logic [1:0] fast;       // fast ram size
	} mem_cfg_t;

	// hdd and controller setup
	typedef struct packed {
		logic       no_fast;  // bit 5, keeps ide on gayle
		logic [1:0] rsvd;
		logic       slave;    // slave drive present
		logic       master;   // master drive present
		logic       gayle_en; // bit 0
	} ide_cfg_t;

	typedef logic [2:0] cache_cfg_t; // cpu cache control bits

endpackage

// File: hw/sys_reset_ctrl.sv
/*
 * system reset sequencer: stretches a reset request over a few
 * video frames and hands a synchronized reset to the cpu
 */
`include "glue_defines.svh"

module sys_reset_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic sof,            // start of frame strobe
	input  logic mrst,           // user or external reset request
	input  logic cpurst,         // cpu only reset
	input  logic cpu_reset_in_n, // reset from the cpu core
	output logic sys_reset,      // core reset
	output logic cpu_reset_n     // reset to the cpu, active low
);

	localparam int CNT_W = $clog2(`GLUE_RESET_FRAMES + 1);

	logic                   hold_q; // stretched request
	logic [CNT_W-1:0]       frame_cnt;
	bus_pkg::cpu_rst_sync_t sync_q; // cpu reset chain

	// ------------------------------
	// frame stretch
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_q    <= 1'b1; // come out of reset held
			frame_cnt <= '0;
		end else if (mrst) begin
			hold_q    <= 1'b1;
			frame_cnt <= '0; // restart the count while requested
		end else if (hold_q && sof) begin
			if (frame_cnt == CNT_W'(`GLUE_RESET_FRAMES - 1)) begin
				hold_q    <= 1'b0; // last frame seen
				frame_cnt <= '0;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// the cpu core can also hold the system in reset
	assign sys_reset = hold_q | ~cpu_reset_in_n;

	// ------------------------------
	// cpu reset synchronizer
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= '0; // cpu held in reset
		end else begin
			sync_q[0] <= ~(cpurst | sys_reset);
			for (int i = 1; i < `GLUE_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1]; // shift towards the output
			end
		end
	end

	assign cpu_reset_n = sync_q[`GLUE_SYNC_STAGES-1];

endmodule

// File: hw/boot_config.sv
/*
 * boot time state and configuration decode: kickstart overlay,
 * video standard latch, memory, cache and ide settings
 */
module boot_config (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clk7_en,
	input  logic                     sys_reset,
	input  logic                     cpu_reset_n,
	input  logic                     cpu_reset_in_n,
	input  logic                     sel_cia_a,     // cia a address space
	input  logic                     cpu_wr,        // any byte write
	input  config_pkg::chipset_cfg_t chipset_cfg,
	input  config_pkg::mem_cfg_t     mem_cfg,
	input  config_pkg::ide_cfg_t     ide_cfg,
	input  logic [1:0]               cpu_cfg,
	input  config_pkg::cache_cfg_t   cache_cfg_pre,
	output logic                     ovl,           // kickstart overlay at 0
	output logic                     ntsc,
	output logic [6:0]               memcfg,
	output config_pkg::cache_cfg_t   cachecfg,
	output logic                     ide_ena,
	output logic                     ide_fast
);

	// overlay maps rom at address 0 until the boot code
	// writes cia a to switch it off
	always_ff @(posedge clk) begin
		if (rst) begin
			ovl <= 1'b1;
		end else if (!cpu_reset_n || !cpu_reset_in_n) begin
			ovl <= 1'b1; // any cpu reset brings the rom back
		end else if (sel_cia_a && cpu_wr) begin
			ovl <= 1'b0;
		end
	end

	// pal/ntsc only switches while reset is held
	always_ff @(posedge clk) begin
		if (rst) begin
			ntsc <= 1'b0; // pal
		end else if (clk7_en && sys_reset) begin
			ntsc <= chipset_cfg.ntsc;
		end
	end

	// ------------------------------
	// derived outputs
	// ------------------------------
	assign memcfg   = {mem_cfg.hrtmon_ext, mem_cfg.slow, mem_cfg.chip, mem_cfg.fast};
	assign cachecfg = {cache_cfg_pre[2], ~ovl, ~ovl}; // no caching over the rom overlay
	assign ide_ena  = ide_cfg.gayle_en;
	assign ide_fast = ~ide_cfg.no_fast & cpu_cfg[1]; // fast ide needs the fast cpu

endmodule

// File: hw/irq_encoder.sv
/*
 * cpu interrupt level encoder, requests arrive already enabled
 * level 7 (freeze) beats everything, output is registered
 */
module irq_encoder (
	input  logic          clk,
	input  logic          rst,
	input  logic          int7,        // freeze button
	input  logic          int6,        // cia b
	input  logic          int3,        // vertical blank and friends
	input  logic          cia_irq,     // cia a, level 2
	input  logic          gayle_irq,
	input  logic          ide_ext_irq, // external fast ide controller
	input  logic          ide_fast,
	output bus_pkg::ipl_t ipl
);

	logic          int2;
	bus_pkg::ipl_t level; // active high level

	// ide interrupt comes from whichever controller owns the drives
	assign int2 = cia_irq | (ide_fast ? ide_ext_irq : gayle_irq);

	always_comb begin
		if (int6)      level = 3'd6;
		else if (int3) level = 3'd3;
		else if (int2) level = 3'd2;
		else           level = 3'd0; // idle
	end

	always_ff @(posedge clk) begin
		if (rst)       ipl <= 3'b111; // no request
		else if (int7) ipl <= 3'b000; // nmi
		else           ipl <= ~level;
	end

endmodule

// File: hw/cpu_read_mux.sv
/*
 * cpu read data merge, every source drives zero when not selected
 * so the sources are simply ORed, the rtc nibble is picked here
 */
`include "glue_defines.svh"

module cpu_read_mux (
	input  logic                            sel_rtc,
	input  logic                            cpu_rd,
	input  bus_pkg::cpu_addr_t              cpu_address,
	input  logic [4*`GLUE_RTC_NIBBLES-1:0]  rtc,        // packed rtc fields
	input  logic [15:0]                     gary_data,
	input  logic [15:0]                     gayle_data,
	input  logic [15:0]                     cart_data,
	input  logic [7:0]                      cia_a_data,
	input  logic [7:0]                      cia_b_data,
	output logic [15:0]                     cpu_data_in
);

	localparam int IDX_W = $clog2(`GLUE_RTC_NIBBLES);

	bus_pkg::cpu_word_u cia_word;
	logic [IDX_W-1:0]   nib_idx;
	logic [15:0]        rtc_data;

	// cia a on the low lane, cia b on the high lane
	always_comb begin
		cia_word.lane.cia_a = cia_a_data;
		cia_word.lane.cia_b = cia_b_data;
	end

	// one rtc field per longword address
	assign nib_idx = cpu_address[IDX_W+1:2];

	always_comb begin
		rtc_data = 16'h0000;
		if (sel_rtc && cpu_rd) begin
			rtc_data[3:0] = rtc[{nib_idx, 2'b00} +: 4]; // upper bits read zero
		end
	end

	assign cpu_data_in = gary_data
		| gayle_data
		| cart_data
		| cia_word.raw
		| rtc_data;

endmodule

// File: hw/minimig_glue.sv
/*
 * system glue top: reset sequencing, boot configuration,
 * interrupt encoding and cpu read merge wired together
 */
`include "glue_defines.svh"

module minimig_glue (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            clk7_en,
	input  logic                            sof,
	input  logic                            mrst,
	input  logic                            cpurst,
	input  logic                            cpu_reset_in_n,
	input  logic                            sel_cia_a,
	input  logic                            sel_rtc,
	input  logic                            cpu_rd,
	input  logic                            cpu_wr,
	input  bus_pkg::cpu_addr_t              cpu_address,
	input  config_pkg::chipset_cfg_t        chipset_cfg,
	input  config_pkg::mem_cfg_t            mem_cfg,
	input  config_pkg::ide_cfg_t            ide_cfg,
	input  logic [1:0]                      cpu_cfg,
	input  config_pkg::cache_cfg_t          cache_cfg_pre,
	input  logic                            int7,
	input  logic                            int6,
	input  logic                            int3,
	input  logic                            cia_irq,
	input  logic                            gayle_irq,
	input  logic                            ide_ext_irq,
	input  logic [4*`GLUE_RTC_NIBBLES-1:0]  rtc,
	input  logic [15:0]                     gary_data,
	input  logic [15:0]                     gayle_data,
	input  logic [15:0]                     cart_data,
	input  logic [7:0]                      cia_a_data,
	input  logic [7:0]                      cia_b_data,
	output logic                            sys_reset,
	output logic                            cpu_reset_n,
	output logic                            ovl,
	output logic                            ntsc,
	output logic [6:0]                      memcfg,
	output config_pkg::cache_cfg_t          cachecfg,
	output logic                            ide_ena,
	output logic                            ide_fast,
	output bus_pkg::ipl_t                   ipl,
	output logic [15:0]                     cpu_data_in
);

	// ------------------------------
	// reset and boot state
	// ------------------------------
	sys_reset_ctrl u_reset (
		.clk(clk), .rst(rst), .sof(sof), .mrst(mrst), .cpurst(cpurst),
		.cpu_reset_in_n(cpu_reset_in_n), .sys_reset(sys_reset), .cpu_reset_n(cpu_reset_n)
	);

	boot_config u_boot (
		.clk(clk), .rst(rst), .clk7_en(clk7_en), .sys_reset(sys_reset),
		.cpu_reset_n(cpu_reset_n), .cpu_reset_in_n(cpu_reset_in_n),
		.sel_cia_a(sel_cia_a), .cpu_wr(cpu_wr), .chipset_cfg(chipset_cfg),
		.mem_cfg(mem_cfg), .ide_cfg(ide_cfg), .cpu_cfg(cpu_cfg),
		.cache_cfg_pre(cache_cfg_pre), .ovl(ovl), .ntsc(ntsc), .memcfg(memcfg),
		.cachecfg(cachecfg), .ide_ena(ide_ena), .ide_fast(ide_fast)
	);

	// ------------------------------
	// cpu side
	// ------------------------------
	irq_encoder u_irq (
		.clk(clk), .rst(rst), .int7(int7), .int6(int6), .int3(int3),
		.cia_irq(cia_irq), .gayle_irq(gayle_irq), .ide_ext_irq(ide_ext_irq),
		.ide_fast(ide_fast), .ipl(ipl) // ide_fast from boot_config
	);

	cpu_read_mux u_rdmux (
		.sel_rtc(sel_rtc), .cpu_rd(cpu_rd), .cpu_address(cpu_address), .rtc(rtc),
		.gary_data(gary_data), .gayle_data(gayle_data), .cart_data(cart_data),
		.cia_a_data(cia_a_data), .cia_b_data(cia_b_data), .cpu_data_in(cpu_data_in)
	);

endmodule

// File: verif/glue_asserts.sv
/*
 * concurrent checks on reset, overlay and interrupt behavior,
 * bound into the glue top
 */
`include "glue_defines.svh"

module glue_asserts (
	input logic          clk,
	input logic          rst,
	input logic          int7,
	input bus_pkg::ipl_t ipl,
	input logic          ovl,
	input logic          sel_cia_a,
	input logic          cpu_wr,
	input logic          sys_reset,
	input logic          cpu_reset_n
);

	// freeze wins one cycle later
	a_int7_ipl: assert property (@(posedge clk) disable iff (rst) int7 |=> ipl == 3'b000)
		else $error("ipl not zero after int7");

	// overlay only drops after a cia a write
	a_ovl_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(ovl) |-> $past(sel_cia_a && cpu_wr))
		else $error("ovl fell without a cia a write");

	a_cpu_rst: assert property (@(posedge clk) disable iff (rst)
		$past(sys_reset, `GLUE_SYNC_STAGES) |-> !cpu_reset_n)
		else $error("cpu_reset_n high too soon after sys_reset");

endmodule

bind minimig_glue glue_asserts u_asserts (
	.clk(clk), .rst(rst), .int7(int7), .ipl(ipl), .ovl(ovl), .sel_cia_a(sel_cia_a),
	.cpu_wr(cpu_wr), .sys_reset(sys_reset), .cpu_reset_n(cpu_reset_n)
);

// File: verif/tb_minimig_glue.sv
/*
 * testbench for the system glue top, runs a table of stimulus rows
 * with expected outputs and reports a single result line
 */
`include "glue_defines.svh"

module tb_minimig_glue;

	typedef struct {
		logic [7:0]  ctl;      // mrst sof cpurst sel_cia_a cpu_wr ntsc_req sel_rtc cpu_rd
		logic [5:0]  irq;      // int7 int6 int3 cia gayle ext
		logic        fast;     // fast ide setup
		logic [3:0]  nib;      // rtc field address
		logic [2:0]  src;      // gary cia_b cia_a
		int          w;        // edges before the check
		logic [6:0]  chk;      // data ipl cfg ntsc ovl cpu_reset_n sys_reset
		logic [3:0]  exp;      // sys_reset cpu_reset_n ovl ntsc
		logic [2:0]  exp_ipl;
		logic [15:0] exp_data;
	} row_t;

	logic clk, rst, clk7_en, sof, mrst, cpurst, cpu_reset_in_n;
	logic sel_cia_a, sel_rtc, cpu_rd, cpu_wr;
	logic int7, int6, int3, cia_irq, gayle_irq, ide_ext_irq;
	bus_pkg::cpu_addr_t       cpu_address;
	config_pkg::chipset_cfg_t chipset_cfg;
	config_pkg::mem_cfg_t     mem_cfg;
	config_pkg::ide_cfg_t     ide_cfg;
	config_pkg::cache_cfg_t   cache_cfg_pre, cachecfg;
	logic [1:0]  cpu_cfg;
	logic [4*`GLUE_RTC_NIBBLES-1:0] rtc;
	logic [15:0] gary_data, gayle_data, cart_data, cpu_data_in;
	logic [7:0]  cia_a_data, cia_b_data;
	logic        sys_reset, cpu_reset_n, ovl, ntsc, ide_ena, ide_fast;
	logic [6:0]  memcfg;
	bus_pkg::ipl_t ipl;

	row_t        table_q[$];
	int          errors = 0;
	int          cycles = 0;
	int          limit = 0;   // set once the table is built
	logic [63:0] rtc_val;
	logic [15:0] gary_val;
	logic [7:0]  cia_a_val, cia_b_val;
	bus_pkg::cpu_addr_t addr_base;

	minimig_glue u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic add_row(input logic [7:0] ctl, input logic [5:0] irq, input logic fast,
			input logic [3:0] nib, input logic [2:0] src, input int w, input logic [6:0] chk,
			input logic [3:0] exp, input logic [2:0] exp_ipl, input logic [15:0] exp_data);
		row_t r;
		r = '{ctl, irq, fast, nib, src, w, chk, exp, exp_ipl, exp_data};
		table_q.push_back(r);
	endtask

	task automatic drive_row(input row_t r);
		bus_pkg::cpu_addr_t a;
		a = addr_base;
		a[5:2] = r.nib; // rtc field select
		{mrst, sof, cpurst, sel_cia_a, cpu_wr} <= r.ctl[7:3];
		{sel_rtc, cpu_rd} <= r.ctl[1:0];
		chipset_cfg <= {3'b000, r.ctl[2], 1'b0};
		{int7, int6, int3, cia_irq, gayle_irq, ide_ext_irq} <= r.irq;
		ide_cfg     <= {~r.fast, 5'b00011}; // master on gayle
		cpu_address <= a;
		gary_data   <= r.src[2] ? gary_val : 16'h0000;
		cia_b_data  <= r.src[1] ? cia_b_val : 8'h00;
		cia_a_data  <= r.src[0] ? cia_a_val : 8'h00;
	endtask

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			errors++;
			$display("Error: %s expected %h got %h", name, exp, act);
		end
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: the table did not finish within %0d cycles", limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int total;
		{rst, clk7_en, sof, mrst, cpurst, sel_cia_a, sel_rtc, cpu_rd, cpu_wr} = 9'b110000000;
		{int7, int6, int3, cia_irq, gayle_irq, ide_ext_irq} = '0;
		cpu_reset_in_n = 1'b1;
		cpu_address = '0;
		chipset_cfg = '0;
		mem_cfg = 8'ha5;       // bit 6 clear, bit 7 set, memcfg gives 7'h65
		ide_cfg = 6'b000011;
		cpu_cfg = 2'b10;       // fast cpu
		cache_cfg_pre = 3'b100;
		{gary_data, gayle_data, cart_data, cia_a_data, cia_b_data} = '0;
		void'($urandom(32'h2668));
		rtc_val = {$urandom, $urandom};
		gary_val = 16'($urandom);
		cia_a_val = 8'($urandom);
		cia_b_val = 8'($urandom);
		addr_base = 23'($urandom);
		rtc = rtc_val;

		// reset stretch over two frames
		add_row(8'h80, 0, 1, 0, 0, 1, 7'h01, 4'b1000, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 1, 7'h01, 4'b1000, 0, 0);
		add_row(8'h40, 0, 1, 0, 0, 0, 7'h01, 4'b1000, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 1, 7'h01, 4'b1000, 0, 0);
		add_row(8'h40, 0, 1, 0, 0, 0, 7'h01, 4'b1000, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 0, 7'h03, 4'b0000, 0, 0); // last sof taken
		add_row(8'h00, 0, 1, 0, 0, 1, 7'h03, 4'b0100, 0, 0); // two stages later
		// cpu reset through the synchronizer
		add_row(8'h20, 0, 1, 0, 0, 1, 7'h02, 4'b0100, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 0, 7'h02, 4'b0000, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 0, 7'h02, 4'b0000, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 0, 7'h02, 4'b0100, 0, 0);
		// overlay, then ntsc latch and config decode
		add_row(8'h08, 0, 1, 0, 0, 1, 7'h1f, 4'b0110, 0, 0);
		add_row(8'h18, 0, 1, 0, 0, 1, 7'h04, 4'b0100, 0, 0);
		add_row(8'h00, 0, 1, 0, 0, 1, 7'h04, 4'b0100, 0, 0);
		add_row(8'h04, 0, 0, 0, 0, 2, 7'h18, 4'b0100, 0, 0); // outside reset, no change
		add_row(8'h84, 0, 0, 0, 0, 2, 7'h09, 4'b1001, 0, 0);
		add_row(8'h44, 0, 0, 0, 0, 0, 7'h00, 4'b0000, 0, 0);
		add_row(8'h04, 0, 0, 0, 0, 0, 7'h00, 4'b0000, 0, 0);
		add_row(8'h44, 0, 0, 0, 0, 0, 7'h00, 4'b0000, 0, 0);
		add_row(8'h04, 0, 0, 0, 0, 3, 7'h0f, 4'b0111, 0, 0);
		add_row(8'h00, 0, 0, 0, 0, 1, 7'h08, 4'b0001, 0, 0);
		// interrupt priority, level inverted
		add_row(8'h00, 6'b111111, 0, 0, 0, 1, 7'h20, 0, 3'b000, 0);
		add_row(8'h00, 6'b011000, 0, 0, 0, 1, 7'h20, 0, 3'b001, 0);
		add_row(8'h00, 6'b001000, 0, 0, 0, 1, 7'h20, 0, 3'b100, 0);
		add_row(8'h00, 6'b000010, 0, 0, 0, 1, 7'h20, 0, 3'b101, 0); // gayle line
		add_row(8'h00, 6'b000001, 0, 0, 0, 1, 7'h20, 0, 3'b111, 0);
		add_row(8'h00, 6'b000001, 1, 0, 0, 1, 7'h20, 0, 3'b101, 0); // external ide
		add_row(8'h00, 6'b000010, 1, 0, 0, 1, 7'h20, 0, 3'b111, 0);
		add_row(8'h00, 6'b000100, 1, 0, 0, 1, 7'h20, 0, 3'b101, 0);
		add_row(8'h00, 6'b000000, 1, 0, 0, 1, 7'h20, 0, 3'b111, 0);
		// read merge
		add_row(8'h03, 0, 1, 3, 0, 0, 7'h40, 0, 0, {12'h0, rtc_val[12 +: 4]});
		add_row(8'h03, 0, 1, 0, 0, 0, 7'h40, 0, 0, {12'h0, rtc_val[0 +: 4]});
		add_row(8'h03, 0, 1, 15, 0, 0, 7'h40, 0, 0, {12'h0, rtc_val[60 +: 4]});
		add_row(8'h02, 0, 1, 9, 0, 0, 7'h40, 0, 0, 16'h0000);
		add_row(8'h01, 0, 1, 9, 0, 0, 7'h40, 0, 0, 16'h0000);
		add_row(8'h00, 0, 1, 0, 3'b001, 0, 7'h40, 0, 0, {8'h00, cia_a_val});
		add_row(8'h00, 0, 1, 0, 3'b010, 0, 7'h40, 0, 0, {cia_b_val, 8'h00});
		add_row(8'h00, 0, 1, 0, 3'b100, 0, 7'h40, 0, 0, gary_val);
		add_row(8'h03, 0, 1, 7, 3'b100, 0, 7'h40, 0, 0, gary_val | {12'h0, rtc_val[28 +: 4]});

		total = 10;
		foreach (table_q[i]) total += table_q[i].w + 1;
		limit = total * 6 / 5; // 20 percent margin

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		foreach (table_q[i]) begin
			@(posedge clk);
			drive_row(table_q[i]);
			repeat (table_q[i].w) @(posedge clk);
			@(negedge clk); // outputs settled
			if (table_q[i].chk[0]) compare("sys_reset", table_q[i].exp[3], sys_reset);
			if (table_q[i].chk[1]) compare("cpu_reset_n", table_q[i].exp[2], cpu_reset_n);
			if (table_q[i].chk[2]) begin
				compare("ovl", table_q[i].exp[1], ovl);
				compare("cachecfg", {1'b1, {2{~table_q[i].exp[1]}}}, cachecfg);
			end
			if (table_q[i].chk[3]) compare("ntsc", table_q[i].exp[0], ntsc);
			if (table_q[i].chk[4]) begin
				compare("memcfg", 7'h65, memcfg);
				compare("ide_ena", 1'b1, ide_ena);
				compare("ide_fast", table_q[i].fast, ide_fast);
			end
			if (table_q[i].chk[5]) compare("ipl", table_q[i].exp_ipl, ipl);
			if (table_q[i].chk[6]) compare("cpu_data_in", table_q[i].exp_data, cpu_data_in);
		end

		$display("rows: %0d  errors: %0d", table_q.size(), errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+hw
hw/bus_pkg.sv
hw/config_pkg.sv
hw/sys_reset_ctrl.sv
hw/boot_config.sv
hw/irq_encoder.sv
hw/cpu_read_mux.sv
hw/minimig_glue.sv
verif/glue_asserts.sv
verif/tb_minimig_glue.sv

// File: run.sh
#!/bin/sh
# build and run the glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -f files.f \
	--top-module tb_minimig_glue -o sim_glue

out=$(./obj_dir/sim_glue 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
